// ==== mmu_pkg.sv ====
package mmu_pkg;

    localparam int TLB_ENTRY_NUM = 16;
    localparam int TLB_IDX_W     = 4;
    localparam int VPPN_W        = 19;
    localparam int PPN_W         = 20;
    localparam int ASID_W        = 10;

    localparam logic [7:0] ADDR_CRMD    = 8'h00;
    localparam logic [7:0] ADDR_ASID    = 8'h04;
    localparam logic [7:0] ADDR_DMW0    = 8'h08;
    localparam logic [7:0] ADDR_DMW1    = 8'h0C;
    localparam logic [7:0] ADDR_TLBIDX  = 8'h10;
    localparam logic [7:0] ADDR_TLBEHI  = 8'h14;
    localparam logic [7:0] ADDR_TLBELO0 = 8'h18;
    localparam logic [7:0] ADDR_TLBELO1 = 8'h1C;
    localparam logic [7:0] ADDR_TLBCMD  = 8'h20;

    typedef enum logic [1:0] {
        KERNEL = 2'd0,
        USER   = 2'd3
    } plv_e;

    typedef enum logic [1:0] {
        LOOKUP_FETCH = 2'd0,
        LOOKUP_LOAD  = 2'd1,
        LOOKUP_STORE = 2'd2
    } lookup_type_e;

    typedef enum logic [1:0] {
        BYTE      = 2'd0,
        HALF_WORD = 2'd1,
        WORD      = 2'd2
    } byte_type_e;

    typedef enum logic [5:0] {
        NONE = 6'h00,
        PIL  = 6'h01,
        PIS  = 6'h02,
        PIF  = 6'h03,
        PME  = 6'h04,
        PPI  = 6'h07,
        ADEF = 6'h08,
        ALE  = 6'h09,
        ADEM = 6'h0A,
        TLBR = 6'h3F
    } ecode_e;

    typedef enum logic [1:0] {
        CMD_TLBWR = 2'd1,
        CMD_TLBRD = 2'd2
    } tlb_cmd_e;

    // crmd fields.
    localparam int CRMD_PLV_LSB  = 0;
    localparam int CRMD_DA       = 3;
    localparam int CRMD_DATF_LSB = 5;
    localparam int CRMD_DATM_LSB = 7;
    localparam logic [31:0] CRMD_MASK  = 32'h0000_01EB;
    localparam logic [31:0] CRMD_RESET = 32'h0000_0008;

    // dmw fields.
    localparam int DMW_PLV0     = 0;
    localparam int DMW_PLV3     = 3;
    localparam int DMW_MAT_LSB  = 4;
    localparam int DMW_PSEG_LSB = 25;
    localparam int DMW_VSEG_LSB = 29;
    localparam logic [31:0] DMW_MASK = 32'hEE00_0039;

    // tlbelo fields; g is shared by both halves of an entry.
    localparam int ELO_V       = 0;
    localparam int ELO_D       = 1;
    localparam int ELO_PLV_LSB = 2;
    localparam int ELO_MAT_LSB = 4;
    localparam int ELO_G       = 6;
    localparam int ELO_PPN_LSB = 8;
    localparam logic [31:0] ELO_MASK = 32'h0FFF_FF7F;

    localparam int TLBIDX_NE    = 31;
    localparam int EHI_VPPN_LSB = 13;

    // flat entry, msb first: e, g, asid, vppn, even half, odd half; top bits are spare.
    localparam int TLB_ENTRY_W   = 88;
    localparam int HALF_W        = 26;
    localparam int ENT_E         = 82;
    localparam int ENT_G         = 81;
    localparam int ENT_ASID_LSB  = 71;
    localparam int ENT_VPPN_LSB  = 52;
    localparam int ENT_H0_LSB    = 26;
    localparam int ENT_H1_LSB    = 0;
    localparam int HALF_PPN_LSB  = 6;
    localparam int HALF_PLV_LSB  = 4;
    localparam int HALF_MAT_LSB  = 2;
    localparam int HALF_D        = 1;
    localparam int HALF_V        = 0;

endpackage

// ==== mmu_csr_regs.sv ====
`timescale 1ns/100ps

module mmu_csr_regs import mmu_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [7:0]                   paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic [31:0]                  crmd,
    output logic [31:0]                  asid,
    output logic [31:0]                  dmw0,
    output logic [31:0]                  dmw1,
    output logic                         tlb_we,
    output logic [TLB_IDX_W-1:0]         tlb_widx,
    output logic [TLB_ENTRY_W-1:0]       tlb_wentry,
    output logic [TLB_IDX_W-1:0]         tlb_ridx,
    input  logic [TLB_ENTRY_W-1:0]       tlb_rentry
);

    logic                 access;
    logic                 wr;
    logic                 addr_ok;
    logic                 cmd_word_ok;
    tlb_cmd_e             cmd;
    logic                 tlb_rd;
    logic [TLB_IDX_W-1:0] idx_index;
    logic                 idx_ne;
    logic [VPPN_W-1:0]    ehi_vppn;
    logic [31:0]          elo0;
    logic [31:0]          elo1;
    logic [HALF_W-1:0]    rhalf0;
    logic [HALF_W-1:0]    rhalf1;

    assign access  = psel & penable;
    assign wr      = access & pwrite & addr_ok;
    assign pready  = access;
    assign pslverr = access & ~addr_ok;

    always_comb begin
        unique case (paddr)
            ADDR_CRMD, ADDR_ASID, ADDR_DMW0, ADDR_DMW1,
            ADDR_TLBIDX, ADDR_TLBEHI, ADDR_TLBELO0, ADDR_TLBELO1,
            ADDR_TLBCMD: addr_ok = 1'b1;
            default:     addr_ok = 1'b0;
        endcase
    end

    assign cmd         = tlb_cmd_e'(pwdata[1:0]);
    assign cmd_word_ok = wr && paddr == ADDR_TLBCMD && pwdata[31:2] == '0;
    assign tlb_we      = cmd_word_ok && cmd == CMD_TLBWR;
    assign tlb_rd      = cmd_word_ok && cmd == CMD_TLBRD;
    assign tlb_widx    = idx_index;
    assign tlb_ridx    = idx_index;

    // g only holds when both halves are global.
    assign tlb_wentry = {5'b0, ~idx_ne, elo0[ELO_G] & elo1[ELO_G],
                         asid[ASID_W-1:0], ehi_vppn,
                         elo0[ELO_PPN_LSB +: PPN_W], elo0[ELO_PLV_LSB +: 2],
                         elo0[ELO_MAT_LSB +: 2], elo0[ELO_D], elo0[ELO_V],
                         elo1[ELO_PPN_LSB +: PPN_W], elo1[ELO_PLV_LSB +: 2],
                         elo1[ELO_MAT_LSB +: 2], elo1[ELO_D], elo1[ELO_V]};

    assign rhalf0 = tlb_rentry[ENT_H0_LSB +: HALF_W];
    assign rhalf1 = tlb_rentry[ENT_H1_LSB +: HALF_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crmd      <= CRMD_RESET;
            asid      <= '0;
            dmw0      <= '0;
            dmw1      <= '0;
            idx_index <= '0;
            idx_ne    <= 1'b0;
            ehi_vppn  <= '0;
            elo0      <= '0;
            elo1      <= '0;
        end else if (tlb_rd) begin
            idx_ne <= ~tlb_rentry[ENT_E]; // an empty entry reads back as zero staging.
            if (tlb_rentry[ENT_E]) begin
                ehi_vppn <= tlb_rentry[ENT_VPPN_LSB +: VPPN_W];
                elo0     <= {4'b0, rhalf0[HALF_PPN_LSB +: PPN_W], 1'b0, tlb_rentry[ENT_G],
                             rhalf0[HALF_MAT_LSB +: 2], rhalf0[HALF_PLV_LSB +: 2],
                             rhalf0[HALF_D], rhalf0[HALF_V]};
                elo1     <= {4'b0, rhalf1[HALF_PPN_LSB +: PPN_W], 1'b0, tlb_rentry[ENT_G],
                             rhalf1[HALF_MAT_LSB +: 2], rhalf1[HALF_PLV_LSB +: 2],
                             rhalf1[HALF_D], rhalf1[HALF_V]};
            end else begin
                ehi_vppn <= '0;
                elo0     <= '0;
                elo1     <= '0;
            end
        end else if (wr) begin
            unique case (paddr)
                ADDR_CRMD:    crmd <= pwdata & CRMD_MASK;
                ADDR_ASID:    asid <= {22'b0, pwdata[ASID_W-1:0]};
                ADDR_DMW0:    dmw0 <= pwdata & DMW_MASK;
                ADDR_DMW1:    dmw1 <= pwdata & DMW_MASK;
                ADDR_TLBIDX: begin
                    idx_index <= pwdata[TLB_IDX_W-1:0];
                    idx_ne    <= pwdata[TLBIDX_NE];
                end
                ADDR_TLBEHI:  ehi_vppn <= pwdata[EHI_VPPN_LSB +: VPPN_W];
                ADDR_TLBELO0: elo0 <= pwdata & ELO_MASK;
                ADDR_TLBELO1: elo1 <= pwdata & ELO_MASK;
                default: ;
            endcase
        end
    end

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            unique case (paddr)
                ADDR_CRMD:    prdata = crmd;
                ADDR_ASID:    prdata = asid;
                ADDR_DMW0:    prdata = dmw0;
                ADDR_DMW1:    prdata = dmw1;
                ADDR_TLBIDX:  prdata = {idx_ne, 27'b0, idx_index};
                ADDR_TLBEHI:  prdata = {ehi_vppn, 13'b0};
                ADDR_TLBELO0: prdata = elo0;
                ADDR_TLBELO1: prdata = elo1;
                default: ;
            endcase
        end
    end

endmodule

// ==== tlb_array.sv ====
`timescale 1ns/100ps

module tlb_array import mmu_pkg::*; (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   tlb_we,
    input  logic [TLB_IDX_W-1:0]                   tlb_widx,
    input  logic [TLB_ENTRY_W-1:0]                 tlb_wentry,
    input  logic [TLB_IDX_W-1:0]                   tlb_ridx,
    output logic [TLB_ENTRY_W-1:0]                 tlb_rentry,
    output logic [TLB_ENTRY_NUM*TLB_ENTRY_W-1:0]   entries
);

    logic [TLB_ENTRY_W-1:0]   mem [TLB_ENTRY_NUM];
    logic [TLB_ENTRY_NUM-1:0] valid_e;

    // only the e bits need a known value after reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_e <= '0;
        end else if (tlb_we) begin
            valid_e[tlb_widx] <= tlb_wentry[ENT_E];
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we) begin
            mem[tlb_widx] <= tlb_wentry;
        end
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRY_NUM; i++) begin
            entries[i*TLB_ENTRY_W +: TLB_ENTRY_W]         = mem[i];
            entries[i*TLB_ENTRY_W + ENT_E]                = valid_e[i];
        end
    end

    assign tlb_rentry = entries[tlb_ridx*TLB_ENTRY_W +: TLB_ENTRY_W];

endmodule

// ==== tlb_lookup.sv ====
`timescale 1ns/100ps

module tlb_lookup import mmu_pkg::*; (
    input  logic [TLB_ENTRY_NUM*TLB_ENTRY_W-1:0] entries,
    input  logic [ASID_W-1:0]                    asid,
    input  logic [1:0]                           plv,
    input  logic [31:0]                          va,
    input  logic [1:0]                           lookup_type,
    output logic [31:0]                          tlb_pa,
    output logic [1:0]                           tlb_mat,
    output ecode_e                               tlb_ecode,
    output logic                                 tlb_is_exc,
    output logic                                 found,
    output logic [TLB_IDX_W-1:0]                 found_idx
);

    logic [TLB_ENTRY_NUM-1:0] hit;
    logic [TLB_ENTRY_W-1:0]   sel_entry;
    logic [HALF_W-1:0]        half;

    genvar g;
    generate
        for (g = 0; g < TLB_ENTRY_NUM; g++) begin : g_match
            logic [TLB_ENTRY_W-1:0] ent;
            assign ent    = entries[g*TLB_ENTRY_W +: TLB_ENTRY_W];
            assign hit[g] = ent[ENT_E] && ent[ENT_VPPN_LSB +: VPPN_W] == va[31:13] &&
                            (ent[ENT_G] || ent[ENT_ASID_LSB +: ASID_W] == asid);
        end
    endgenerate

    // walk downward so the lowest matching index wins.
    always_comb begin
        found     = 1'b0;
        found_idx = '0;
        for (int i = TLB_ENTRY_NUM - 1; i >= 0; i--) begin
            if (hit[i]) begin
                found     = 1'b1;
                found_idx = TLB_IDX_W'(i);
            end
        end
    end

    assign sel_entry = entries[found_idx*TLB_ENTRY_W +: TLB_ENTRY_W];
    assign half      = va[12] ? sel_entry[ENT_H1_LSB +: HALF_W] :
                                sel_entry[ENT_H0_LSB +: HALF_W];
    assign tlb_pa    = {half[HALF_PPN_LSB +: PPN_W], va[11:0]};
    assign tlb_mat   = half[HALF_MAT_LSB +: 2];

    always_comb begin
        tlb_ecode = NONE;
        if (!found) begin
            tlb_ecode = TLBR;
        end else if (!half[HALF_V]) begin
            unique case (lookup_type)
                LOOKUP_FETCH: tlb_ecode = PIF;
                LOOKUP_STORE: tlb_ecode = PIS;
                default:      tlb_ecode = PIL;
            endcase
        end else if (plv > half[HALF_PLV_LSB +: 2]) begin
            tlb_ecode = PPI;
        end else if (lookup_type == LOOKUP_STORE && !half[HALF_D]) begin
            tlb_ecode = PME;
        end
    end

    assign tlb_is_exc = tlb_ecode != NONE;

endmodule

// ==== addr_trans.sv ====
`timescale 1ns/100ps

module addr_trans import mmu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  logic [31:0]          va,
    input  logic [1:0]           lookup_type,
    input  logic [1:0]           byte_type,
    input  logic [31:0]          crmd,
    input  logic [31:0]          dmw0,
    input  logic [31:0]          dmw1,
    input  logic [31:0]          tlb_pa,
    input  logic [1:0]           tlb_mat,
    input  ecode_e               tlb_ecode,
    input  logic                 tlb_is_exc,
    input  logic                 found,
    input  logic [TLB_IDX_W-1:0] found_idx,
    output logic                 rsp_valid,
    output logic [31:0]          pa,
    output logic [1:0]           mat,
    output logic                 excp_valid,
    output ecode_e               ecode,
    output logic [31:0]          badv,
    output logic                 rsp_found,
    output logic [TLB_IDX_W-1:0] rsp_found_idx
);

    logic       is_fetch;
    logic [1:0] plv;
    logic       dmw0_hit;
    logic       dmw1_hit;
    logic       is_direct;
    logic       is_tlb;
    logic       align_ok;
    logic [31:0] pa_d;
    logic [1:0]  mat_d;
    ecode_e      ecode_d;

    assign is_fetch  = lookup_type == LOOKUP_FETCH;
    assign plv       = crmd[CRMD_PLV_LSB +: 2];
    assign is_direct = crmd[CRMD_DA];

    assign dmw0_hit = dmw0[DMW_VSEG_LSB +: 3] == va[31:29] &&
                      ((plv == KERNEL && dmw0[DMW_PLV0]) || (plv == USER && dmw0[DMW_PLV3]));
    assign dmw1_hit = dmw1[DMW_VSEG_LSB +: 3] == va[31:29] &&
                      ((plv == KERNEL && dmw1[DMW_PLV0]) || (plv == USER && dmw1[DMW_PLV3]));
    assign is_tlb   = !is_direct && !dmw0_hit && !dmw1_hit;

    always_comb begin
        if (is_direct) begin
            pa_d  = va;
            mat_d = is_fetch ? crmd[CRMD_DATF_LSB +: 2] : crmd[CRMD_DATM_LSB +: 2];
        end else if (dmw0_hit) begin
            pa_d  = {dmw0[DMW_PSEG_LSB +: 3], va[28:0]};
            mat_d = dmw0[DMW_MAT_LSB +: 2];
        end else if (dmw1_hit) begin
            pa_d  = {dmw1[DMW_PSEG_LSB +: 3], va[28:0]};
            mat_d = dmw1[DMW_MAT_LSB +: 2];
        end else begin
            pa_d  = tlb_pa;
            mat_d = tlb_mat;
        end
    end

    always_comb begin
        unique case (byte_type)
            HALF_WORD: align_ok = ~va[0];
            WORD:      align_ok = ~|va[1:0];
            default:   align_ok = 1'b1;
        endcase
    end

    always_comb begin
        ecode_d = NONE;
        if (!align_ok) begin
            ecode_d = is_fetch ? ADEF : ALE;
        end else if (plv == USER && va[31] && is_tlb) begin
            ecode_d = is_fetch ? ADEF : ADEM; // user space ends at the 2 GiB line.
        end else if (is_tlb && tlb_is_exc) begin
            ecode_d = tlb_ecode;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid  <= 1'b0;
            excp_valid <= 1'b0;
            ecode      <= NONE;
        end else begin
            rsp_valid  <= req_valid;
            excp_valid <= req_valid && ecode_d != NONE;
            ecode      <= req_valid ? ecode_d : NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            pa            <= pa_d;
            mat           <= mat_d;
            badv          <= va;
            rsp_found     <= found;
            rsp_found_idx <= found_idx;
        end
    end

endmodule

// ==== mmu_top.sv ====
`timescale 1ns/100ps

module mmu_top import mmu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [7:0]           paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  logic                 req_valid,
    input  logic [31:0]          va,
    input  logic [1:0]           lookup_type,
    input  logic [1:0]           byte_type,
    output logic                 rsp_valid,
    output logic [31:0]          pa,
    output logic [1:0]           mat,
    output logic                 excp_valid,
    output ecode_e               ecode,
    output logic [31:0]          badv,
    output logic                 found,
    output logic [TLB_IDX_W-1:0] found_idx
);

    logic [31:0]                         crmd;
    logic [31:0]                         asid;
    logic [31:0]                         dmw0;
    logic [31:0]                         dmw1;
    logic                                tlb_we;
    logic [TLB_IDX_W-1:0]                tlb_widx;
    logic [TLB_ENTRY_W-1:0]              tlb_wentry;
    logic [TLB_IDX_W-1:0]                tlb_ridx;
    logic [TLB_ENTRY_W-1:0]              tlb_rentry;
    logic [TLB_ENTRY_NUM*TLB_ENTRY_W-1:0] entries;
    logic [31:0]                         tlb_pa;
    logic [1:0]                          tlb_mat;
    ecode_e                              tlb_ecode;
    logic                                tlb_is_exc;
    logic                                lk_found;
    logic [TLB_IDX_W-1:0]                lk_found_idx;

    mmu_csr_regs u_csr (
        .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .crmd, .asid, .dmw0, .dmw1,
        .tlb_we, .tlb_widx, .tlb_wentry, .tlb_ridx, .tlb_rentry
    );

    tlb_array u_array (
        .clk, .rst_n, .tlb_we, .tlb_widx, .tlb_wentry, .tlb_ridx,
        .tlb_rentry, .entries
    );

    tlb_lookup u_lookup (
        .entries,
        .asid        (asid[ASID_W-1:0]),
        .plv         (crmd[CRMD_PLV_LSB +: 2]),
        .va, .lookup_type,
        .tlb_pa, .tlb_mat, .tlb_ecode, .tlb_is_exc,
        .found       (lk_found),
        .found_idx   (lk_found_idx)
    );

    addr_trans u_trans (
        .clk, .rst_n, .req_valid, .va, .lookup_type, .byte_type,
        .crmd, .dmw0, .dmw1,
        .tlb_pa, .tlb_mat, .tlb_ecode, .tlb_is_exc,
        .found         (lk_found),
        .found_idx     (lk_found_idx),
        .rsp_valid, .pa, .mat, .excp_valid, .ecode, .badv,
        .rsp_found     (found),
        .rsp_found_idx (found_idx)
    );

endmodule

// ==== mmu_props.sv ====
`timescale 1ns/100ps

module mmu_props import mmu_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       psel,
    input logic       penable,
    input logic       pready,
    input logic       req_valid,
    input logic       rsp_valid,
    input logic       excp_valid,
    input logic [5:0] ecode
);

    a_pready: assert property (@(posedge clk) disable iff (!rst_n)
        pready == (psel && penable))
        else $error("pready does not match the access phase");

    a_rsp_follow: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid == $past(req_valid))
        else $error("rsp_valid is not req_valid delayed by one cycle");

    a_ecode_none: assert property (@(posedge clk) disable iff (!rst_n)
        !excp_valid |-> ecode == NONE)
        else $error("ecode set without excp_valid");

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !rsp_valid)
        else $error("rsp_valid high during reset");

endmodule

bind mmu_top mmu_props props0 (
    .clk, .rst_n, .psel, .penable, .pready, .req_valid, .rsp_valid, .excp_valid,
    .ecode (ecode)
);

// ==== mmu_checker.sv ====
`timescale 1ns/100ps

module mmu_checker import mmu_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        rsp_valid,
    input logic [31:0] pa,
    input logic [1:0]  mat,
    input logic        excp_valid,
    input logic [5:0]  ecode,
    input logic [31:0] badv,
    input logic        found,
    input logic [3:0]  found_idx
);

    typedef struct packed {
        logic [31:0] va;
        logic [31:0] pa;
        logic [1:0]  mat;
        logic        excp;
        logic [5:0]  ecode;
        logic        found;
        logic [3:0]  idx;
    } exp_t;

    exp_t exp_q[$];
    int   errors = 0;

    task automatic push_expect(input logic [31:0] v, input logic [31:0] p, input logic [1:0] m,
                               input logic ex, input logic [5:0] ec, input logic fnd,
                               input logic [3:0] idx);
        exp_q.push_back('{v, p, m, ex, ec, fnd, idx});
    endtask

    task automatic compare(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("ERR %s: expected %h, actual %h", name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic report_leftover();
        if (exp_q.size() != 0) begin
            $display("%0d expected responses never arrived", exp_q.size());
            errors++;
        end
    endtask

    // outputs are registered on the rising edge, so the falling edge sees them settled.
    always @(negedge clk) begin
        exp_t e;
        if (rst_n && rsp_valid) begin
            if (exp_q.size() == 0) begin
                $display("a response arrived with no request outstanding");
                errors++;
            end else begin
                e = exp_q.pop_front();
                compare("excp_valid", 32'(e.excp), 32'(excp_valid));
                compare("ecode", 32'(e.ecode), 32'(ecode));
                compare("badv", e.va, badv);
                compare("found", 32'(e.found), 32'(found));
                if (e.found) begin
                    compare("found_idx", 32'(e.idx), 32'(found_idx));
                end
                if (!e.excp) begin
                    compare("pa", e.pa, pa);
                    compare("mat", 32'(e.mat), 32'(mat));
                end
            end
        end
    end

endmodule

// ==== tb_mmu.sv ====
`timescale 1ns/100ps

module tb_mmu import mmu_pkg::*; ();

    localparam int CLK_PERIOD = 20;

    typedef struct {
        int          phase;
        logic        wr;
        logic [7:0]  addr;
        logic [31:0] data;
        logic        err;
    } cfg_row_t;

    typedef struct {
        int          phase;
        logic [1:0]  lt;
        logic [1:0]  bt;
        logic [31:0] va;
        logic [31:0] rmask;
        logic [31:0] pa;
        logic [1:0]  mat;
        logic        excp;
        logic [5:0]  ecode;
        logic        found;
        logic [3:0]  idx;
    } trans_row_t;

    logic        clk;
    logic        rst_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        req_valid;
    logic [31:0] va;
    logic [1:0]  lookup_type;
    logic [1:0]  byte_type;
    logic        rsp_valid;
    logic [31:0] pa;
    logic [1:0]  mat;
    logic        excp_valid;
    ecode_e      ecode;
    logic [31:0] badv;
    logic        found;
    logic [3:0]  found_idx;

    cfg_row_t   cfg_q[$];
    trans_row_t trans_q[$];
    int         apb_errors = 0;
    int         cycles = 0;
    int         cycle_limit = 1000;

    mmu_top dut0 (.*);

    mmu_checker chk0 (
        .clk, .rst_n, .rsp_valid, .pa, .mat, .excp_valid,
        .ecode (ecode), .badv, .found, .found_idx
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic add_cfg(input int ph, input logic wr, input logic [7:0] addr,
                           input logic [31:0] data, input logic err);
        cfg_q.push_back('{ph, wr, addr, data, err});
    endtask

    task automatic add_row(input int ph, input logic [1:0] lt, input logic [1:0] bt,
                           input logic [31:0] v, input logic [31:0] rmask,
                           input logic [31:0] p, input logic [1:0] m, input logic ex,
                           input logic [5:0] ec, input logic fnd, input logic [3:0] idx);
        trans_q.push_back('{ph, lt, bt, v, rmask, p, m, ex, ec, fnd, idx});
    endtask

    // the tasks sample a quarter period into the access phase.
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        if (pready !== 1'b1) begin
            $display("ERR pready: expected %h, actual %h", 1'b1, pready);
            apb_errors++;
        end
        if (pslverr !== exp_err) begin
            $display("ERR pslverr: expected %h, actual %h", exp_err, pslverr);
            apb_errors++;
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        pwdata  = '0;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        if (pready !== 1'b1) begin
            $display("ERR pready: expected %h, actual %h", 1'b1, pready);
            apb_errors++;
        end
        if (pslverr !== exp_err) begin
            $display("ERR pslverr: expected %h, actual %h", exp_err, pslverr);
            apb_errors++;
        end
        if (prdata !== exp_data) begin
            $display("ERR prdata: expected %h, actual %h", exp_data, prdata);
            apb_errors++;
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic build_tables();
        // phase 0 runs direct mode with datf 1 and datm 2.
        add_cfg(0, 1, ADDR_CRMD, 32'h0000_0128, 0);
        add_row(0, LOOKUP_FETCH, WORD, 32'h1234_0078, 32'h0000_FF00, 32'h1234_0078,
                1, 0, NONE, 0, 0);
        add_row(0, LOOKUP_LOAD,  WORD, 32'h8000_0010, 0, 32'h8000_0010, 2, 0, NONE, 0, 0);
        add_row(0, LOOKUP_STORE, BYTE, 32'h0000_0003, 0, 32'h0000_0003, 2, 0, NONE, 0, 0);
        add_row(0, LOOKUP_LOAD,  WORD, 32'h1000_0002, 0, 0, 0, 1, ALE, 0, 0);
        // phase 1 fills entries 7, 3 and 5, reads 7 and 3 back, then maps the windows.
        add_cfg(1, 1, ADDR_ASID, 32'h0000_002A, 0);
        add_cfg(1, 1, ADDR_TLBIDX, 32'h0000_0007, 0);
        add_cfg(1, 1, ADDR_TLBEHI, 32'h0080_0000, 0);
        add_cfg(1, 1, ADDR_TLBELO0, 32'h0009_9903, 0);
        add_cfg(1, 1, ADDR_TLBELO1, 32'h000A_AA03, 0);
        add_cfg(1, 1, ADDR_TLBCMD, 32'h0000_0001, 0);
        add_cfg(1, 1, ADDR_TLBIDX, 32'h0000_0003, 0);
        add_cfg(1, 1, ADDR_TLBEHI, 32'h0040_0000, 0);
        add_cfg(1, 1, ADDR_TLBELO0, 32'h0123_455F, 0);
        add_cfg(1, 1, ADDR_TLBELO1, 32'h00AB_CD6F, 0);
        add_cfg(1, 1, ADDR_TLBCMD, 32'h0000_0001, 0);
        add_cfg(1, 1, ADDR_TLBIDX, 32'h0000_0005, 0);
        add_cfg(1, 1, ADDR_TLBEHI, 32'h0060_0000, 0);
        add_cfg(1, 1, ADDR_TLBELO0, 32'h0007_771D, 0);
        add_cfg(1, 1, ADDR_TLBELO1, 32'h0008_881C, 0);
        add_cfg(1, 1, ADDR_TLBCMD, 32'h0000_0001, 0);
        add_cfg(1, 1, ADDR_TLBIDX, 32'h0000_0007, 0);
        add_cfg(1, 1, ADDR_TLBCMD, 32'h0000_0002, 0);
        add_cfg(1, 0, ADDR_TLBIDX, 32'h0000_0007, 0);
        add_cfg(1, 0, ADDR_TLBEHI, 32'h0080_0000, 0);
        add_cfg(1, 0, ADDR_TLBELO0, 32'h0009_9903, 0);
        add_cfg(1, 0, ADDR_TLBELO1, 32'h000A_AA03, 0);
        add_cfg(1, 1, ADDR_TLBIDX, 32'h0000_0003, 0);
        add_cfg(1, 1, ADDR_TLBCMD, 32'h0000_0002, 0);
        add_cfg(1, 0, ADDR_TLBIDX, 32'h0000_0003, 0);
        add_cfg(1, 0, ADDR_TLBEHI, 32'h0040_0000, 0);
        add_cfg(1, 0, ADDR_TLBELO0, 32'h0123_455F, 0);
        add_cfg(1, 0, ADDR_TLBELO1, 32'h00AB_CD6F, 0);
        add_cfg(1, 1, ADDR_DMW0, 32'h8000_0011, 0);
        add_cfg(1, 1, ADDR_DMW1, 32'hA400_0028, 0);
        add_cfg(1, 1, ADDR_CRMD, 32'h0000_0000, 0);
        add_row(1, LOOKUP_LOAD,  WORD, 32'h8000_1234, 0, 32'h0000_1234, 1, 0, NONE, 0, 0);
        add_row(1, LOOKUP_LOAD,  WORD, 32'hA000_0100, 0, 0, 0, 1, TLBR, 0, 0);
        add_row(1, LOOKUP_FETCH, WORD, 32'h0040_0010, 0, 32'h1234_5010, 1, 0, NONE, 1, 3);
        add_row(1, LOOKUP_LOAD,  WORD, 32'h0040_1ABC, 0, 32'h0ABC_DABC, 2, 0, NONE, 1, 3);
        add_row(1, LOOKUP_STORE, WORD, 32'h0040_1000, 0, 32'h0ABC_D000, 2, 0, NONE, 1, 3);
        add_row(1, LOOKUP_LOAD,  WORD, 32'h0060_0004, 0, 32'h0077_7004, 1, 0, NONE, 1, 5);
        add_row(1, LOOKUP_STORE, WORD, 32'h0060_0008, 0, 0, 0, 1, PME, 1, 5);
        add_row(1, LOOKUP_LOAD,  WORD, 32'h0060_1000, 0, 0, 0, 1, PIL, 1, 5);
        add_row(1, LOOKUP_FETCH, WORD, 32'h0060_1000, 0, 0, 0, 1, PIF, 1, 5);
        add_row(1, LOOKUP_STORE, WORD, 32'h0060_1004, 0, 0, 0, 1, PIS, 1, 5);
        add_row(1, LOOKUP_LOAD,  HALF_WORD, 32'h0060_1001, 0, 0, 0, 1, ALE, 1, 5);
        add_row(1, LOOKUP_FETCH, WORD, 32'h0040_0002, 0, 0, 0, 1, ADEF, 1, 3);
        // phase 2 puts both windows on the same segment under another ASID.
        add_cfg(2, 1, ADDR_ASID, 32'h0000_0015, 0);
        add_cfg(2, 1, ADDR_DMW1, 32'h8200_0021, 0);
        add_row(2, LOOKUP_LOAD,  WORD, 32'h8000_0040, 0, 32'h0000_0040, 1, 0, NONE, 0, 0);
        add_row(2, LOOKUP_LOAD,  WORD, 32'h0060_0004, 0, 0, 0, 1, TLBR, 0, 0);
        add_row(2, LOOKUP_LOAD,  WORD, 32'h0040_0004, 0, 32'h1234_5004, 1, 0, NONE, 1, 3);
        // phase 3 runs in user mode.
        add_cfg(3, 1, ADDR_ASID, 32'h0000_002A, 0);
        add_cfg(3, 1, ADDR_DMW1, 32'hA400_0028, 0);
        add_cfg(3, 1, ADDR_CRMD, 32'h0000_0003, 0);
        add_row(3, LOOKUP_LOAD,  WORD, 32'hA000_0100, 0, 32'h4000_0100, 2, 0, NONE, 0, 0);
        add_row(3, LOOKUP_LOAD,  WORD, 32'h8000_0040, 0, 0, 0, 1, ADEM, 0, 0);
        add_row(3, LOOKUP_FETCH, WORD, 32'h9000_0000, 0, 0, 0, 1, ADEF, 0, 0);
        add_row(3, LOOKUP_LOAD,  WORD, 32'h0080_0000, 0, 0, 0, 1, PPI, 1, 7);
        add_row(3, LOOKUP_LOAD,  WORD, 32'h0040_0008, 32'h0000_0FF0, 32'h1234_5008,
                1, 0, NONE, 1, 3);
        add_row(3, LOOKUP_LOAD,  HALF_WORD, 32'h8000_0041, 0, 0, 0, 1, ALE, 0, 0);
        // an unmapped address must not disturb anything, and plv 1 opens no window.
        add_cfg(4, 1, 8'h24, 32'hFFFF_FFFF, 1);
        add_cfg(4, 0, 8'h24, 32'h0000_0000, 1);
        add_cfg(4, 0, ADDR_CRMD, 32'h0000_0003, 0);
        add_cfg(4, 0, ADDR_DMW1, 32'hA400_0028, 0);
        add_cfg(4, 1, ADDR_CRMD, 32'h0000_0001, 0);
        add_row(4, LOOKUP_LOAD,  WORD, 32'h8000_0040, 0, 0, 0, 1, TLBR, 0, 0);
    endtask

    initial begin
        logic [31:0] fill;
        int          total;
        void'($urandom(32'ha17b_288a));
        rst_n       = 1'b0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        req_valid   = 1'b0;
        va          = '0;
        lookup_type = LOOKUP_FETCH;
        byte_type   = BYTE;
        build_tables();
        cycle_limit = 4 * (cfg_q.size() * 2 + trans_q.size()) + 100;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int ph = 0; ph <= 4; ph++) begin
            foreach (cfg_q[i]) begin
                if (cfg_q[i].phase == ph) begin
                    if (cfg_q[i].wr) begin
                        apb_write(cfg_q[i].addr, cfg_q[i].data, cfg_q[i].err);
                    end else begin
                        apb_read(cfg_q[i].addr, cfg_q[i].data, cfg_q[i].err);
                    end
                end
            end
            foreach (trans_q[i]) begin
                if (trans_q[i].phase == ph) begin
                    @(negedge clk);
                    fill        = $urandom & trans_q[i].rmask; // free offset bits.
                    req_valid   = 1'b1;
                    va          = trans_q[i].va | fill;
                    lookup_type = trans_q[i].lt;
                    byte_type   = trans_q[i].bt;
                    chk0.push_expect(trans_q[i].va | fill, trans_q[i].pa | fill,
                                     trans_q[i].mat, trans_q[i].excp, trans_q[i].ecode,
                                     trans_q[i].found, trans_q[i].idx);
                end
            end
            @(negedge clk);
            req_valid = 1'b0;
            while (chk0.exp_q.size() != 0) begin
                @(negedge clk);
            end
        end
        repeat (2) @(negedge clk);
        chk0.report_leftover();
        total = chk0.errors + apb_errors;
        $display("errors: checker %0d, apb %0d, total %0d", chk0.errors, apb_errors, total);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
mmu_pkg.sv
mmu_csr_regs.sv
tlb_array.sv
tlb_lookup.sv
addr_trans.sv
mmu_top.sv
mmu_props.sv
mmu_checker.sv
tb_mmu.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_mmu -f compile.f -o tb_mmu_sim &&
./obj_dir/tb_mmu_sim | tee /dev/stderr | grep -q "^Simulation passed$" &&
echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }
